// File: compile.f
hdl/holo_bridge_pkg.sv
hdl/spi_xfer_if.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/spi_master.sv
hdl/byte_pairer.sv
hdl/reset_stretcher.sv
hdl/reply_queue.sv
hdl/holo_bridge_top.sv
testbench/holo_bridge_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module holo_bridge_tb -f compile.f -o holo_bridge_sim

out=$(./obj_dir/holo_bridge_sim)
echo "$out"

if grep -q "Simulation passed" <<< "$out"; then
  exit 0
else
  exit 1
fi

// File: testbench/holo_bridge_tb.sv
// runs with clks_per_bit 16; the slave answers address xor 8'h5a and no line faults are injected
`timescale 1ns/1ps

module holo_bridge_tb;

  localparam int CPB = 16;
  localparam int NUM_BYTES = 8;
  localparam int HOLD_CYCLES = 10;

  logic sys_clk;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic uart_tx_o;
  logic spi_sen_o;
  logic spi_sck_o;
  logic spi_sdat_o;
  logic spi_sout_i;
  logic slm_reset_n_o;

  integer     seed = 32'h472b_3059;
  // bytes in send order, sent_cnt bumps as each stop bit begins
  logic [7:0] sent [16];
  int         sent_cnt = 0;
  // spi slave state
  logic [15:0] mosi_word;
  logic [7:0]  reply;
  int          bit_cnt = 0;
  int          frames = 0;
  // uart monitor state
  logic [7:0] mon_byte;
  logic       mon_stop;
  logic       mon_valid;
  int         replies = 0;
  // reset bookkeeping
  logic rst_d = 1'b0;
  int   low_cycles = 0;
  // one counter per check
  int err_rst = 0;
  int err_hold = 0;
  int err_sck = 0;
  int err_pair = 0;
  int err_frame = 0;
  int err_reply = 0;
  int err_count = 0;

  holo_bridge_top #(.clks_per_bit(CPB)) dut0 (
    .sys_clk        (sys_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .uart_rx_i      (uart_rx_i),
    .uart_tx_o      (uart_tx_o),
    .spi_sen_o      (spi_sen_o),
    .spi_sck_o      (spi_sck_o),
    .spi_sdat_o     (spi_sdat_o),
    .spi_sout_i     (spi_sout_i),
    .slm_reset_n_o  (slm_reset_n_o)
  );

  initial begin
    sys_clk = 1'b0;
    forever #20 sys_clk = ~sys_clk;
  end

  always @(posedge sys_clk) begin
    rst_d <= reset_all_cmd_w;
    // cycles since the reset command dropped, saturating
    if (reset_all_cmd_w) begin
      low_cycles <= 0;
    end else if (low_cycles < 1000) begin
      low_cycles <= low_cycles + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // uart driver, lsb first, one bit per CPB clocks
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_byte(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    sent[sent_cnt] = value;
    for (int k = 0; k < 10; k++) begin
      if (k == 9) begin
        sent_cnt++;
      end
      @(posedge sys_clk);
      #2;
      uart_rx_i = frame[k];
      repeat (CPB - 1) @(posedge sys_clk);
    end
  endtask

  // decodes replies at bit centres on the falling clock
  initial begin
    mon_valid = 1'b0;
    forever begin
      @(negedge uart_tx_o);
      repeat (CPB / 2) @(negedge sys_clk);
      for (int i = 0; i < 8; i++) begin
        repeat (CPB) @(negedge sys_clk);
        mon_byte[i] = uart_tx_o;
      end
      repeat (CPB) @(negedge sys_clk);
      mon_stop = uart_tx_o;
      mon_valid = 1'b1;
      @(negedge sys_clk);
      mon_valid = 1'b0;
      replies++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // spi slave model
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    spi_sout_i = 1'b0;
    forever begin
      @(negedge spi_sen_o);
      bit_cnt = 0;
      while (spi_sen_o === 1'b0) begin
        @(posedge spi_sck_o or posedge spi_sen_o);
        if (spi_sen_o === 1'b0) begin
          mosi_word = {mosi_word[14:0], spi_sdat_o};
          bit_cnt++;
          // address known after eight bits, reply goes out msb first
          if (bit_cnt == 8) begin
            reply = mosi_word[7:0] ^ 8'h5A;
          end
          #2;
          spi_sout_i = (bit_cnt >= 8 && bit_cnt < 16) ? reply[15 - bit_cnt] : 1'b0;
        end
      end
      frames++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge sys_clk) rst_d |-> (spi_sen_o && !spi_sck_o && uart_tx_o))
    else begin
      err_rst++;
      $display("CHECK FAILED spi_sen_o/spi_sck_o/uart_tx_o: got %h %h %h expected 1 0 1",
               $sampled(spi_sen_o), $sampled(spi_sck_o), $sampled(uart_tx_o));
    end

  assert property (@(posedge sys_clk) slm_reset_n_o == (low_cycles >= HOLD_CYCLES))
    else begin
      err_hold++;
      $display("CHECK FAILED slm_reset_n_o: got %h expected %h",
               $sampled(slm_reset_n_o), $sampled(low_cycles >= HOLD_CYCLES));
    end

  assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
                   spi_sen_o |-> !spi_sck_o)
    else begin
      err_sck++;
      $display("CHECK FAILED spi_sck_o: got %h expected 0 while deselected", $sampled(spi_sck_o));
    end

  // a frame may only open once a full pair has arrived
  assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
                   $fell(spi_sen_o) |-> (sent_cnt == 2 * frames + 2))
    else begin
      err_pair++;
      $display("CHECK FAILED sent byte count at spi_sen_o fall: got %h expected %h",
               sent_cnt, 2 * frames + 2);
    end

  assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
                   $rose(spi_sen_o) |->
                   (bit_cnt == 16 && mosi_word == {sent[2 * frames - 2], sent[2 * frames - 1]}))
    else begin
      err_frame++;
      $display("CHECK FAILED spi_sdat_o frame: got %h expected %h with %h sck edges",
               mosi_word, {sent[2 * frames - 2], sent[2 * frames - 1]}, bit_cnt);
    end

  assert property (@(posedge sys_clk)
                   mon_valid |-> (mon_stop && mon_byte == (sent[2 * replies] ^ 8'h5A)))
    else begin
      err_reply++;
      $display("CHECK FAILED uart_tx_o reply: got %h expected %h stop %h",
               mon_byte, sent[2 * replies] ^ 8'h5A, mon_stop);
    end

  // limit scales with the uart traffic
  initial begin
    repeat (2 * (NUM_BYTES * 10 * CPB + 200)) @(posedge sys_clk);
    $display("timeout: the expected frames and replies did not all arrive");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int rnd;
    int total;
    reset_all_cmd_w = 1'b1;
    uart_rx_i = 1'b1;
    repeat (5) @(posedge sys_clk);
    #2;
    reset_all_cmd_w = 1'b0;
    // lone byte first, then a gap where no frame may start
    for (int n = 0; n < NUM_BYTES; n++) begin
      rnd = $random(seed);
      send_byte(rnd[7:0]);
      if (n == 0) begin
        repeat (4 * CPB) @(posedge sys_clk);
      end
    end
    wait (frames == NUM_BYTES / 2);
    wait (replies == NUM_BYTES / 2);
    // quiet period to catch stray frames or replies
    repeat (20 * CPB) @(posedge sys_clk);
    assert (frames == NUM_BYTES / 2 && replies == NUM_BYTES / 2)
      else begin
        err_count++;
        $display("CHECK FAILED frame/reply count: got %h %h expected %h",
                 frames, replies, NUM_BYTES / 2);
      end
    total = err_rst + err_hold + err_sck + err_pair + err_frame + err_reply + err_count;
    $display("errors: reset %0d hold %0d sck %0d pair %0d frame %0d reply %0d count %0d",
             err_rst, err_hold, err_sck, err_pair, err_frame, err_reply, err_count);
    if (total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: hdl/holo_bridge_top.sv
// sys_clk must already be clean at the rate that clks_per_bit was set for
`timescale 1ns/1ps

module holo_bridge_top #(
  parameter int clks_per_bit = holo_bridge_pkg::CLKS_PER_BIT_DEFAULT
) (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_sdat_o,
  input  logic spi_sout_i,
  output logic slm_reset_n_o
);
  import holo_bridge_pkg::*;

  logic  rx_valid;
  byte_t rx_byte;
  logic  tx_start;
  byte_t tx_byte;
  logic  tx_active;

  spi_xfer_if xfer_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // pc side uart
  ////////////////////////////////////////////////////////////////////////////

  uart_rx #(.clks_per_bit(clks_per_bit)) u_uart_rx (
    .sys_clk        (sys_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .rx_serial_i    (uart_rx_i),
    .rx_valid_o     (rx_valid),
    .rx_byte_o      (rx_byte)
  );

  uart_tx #(.clks_per_bit(clks_per_bit)) u_uart_tx (
    .sys_clk        (sys_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .tx_start_i     (tx_start),
    .tx_byte_i      (tx_byte),
    .tx_active_o    (tx_active),
    .tx_serial_o    (uart_tx_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // slm side spi and reset
  ////////////////////////////////////////////////////////////////////////////

  // address then data pairs
  byte_pairer u_byte_pairer (
    .sys_clk        (sys_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .rx_valid_i     (rx_valid),
    .rx_byte_i      (rx_byte),
    .xfer           (xfer_bus.requester)
  );

  spi_master u_spi_master (
    .sys_clk        (sys_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .xfer           (xfer_bus.engine),
    .sen_o          (spi_sen_o),
    .sck_o          (spi_sck_o),
    .sdat_o         (spi_sdat_o),
    .sout_i         (spi_sout_i)
  );

  // read-back bytes queued for the uart
  reply_queue u_reply_queue (
    .sys_clk        (sys_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .xfer           (xfer_bus.result),
    .tx_active_i    (tx_active),
    .tx_start_o     (tx_start),
    .tx_byte_o      (tx_byte)
  );

  reset_stretcher u_reset_stretcher (
    .sys_clk        (sys_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .slm_reset_n_o  (slm_reset_n_o)
  );

endmodule

// File: hdl/reply_queue.sv
// four entries; replies arriving while full are dropped without any flag
`timescale 1ns/1ps

module reply_queue (
  input  logic                   sys_clk,
  input  logic                   reset_all_cmd_w,
  spi_xfer_if.result             xfer,
  input  logic                   tx_active_i,
  output logic                   tx_start_o,
  output holo_bridge_pkg::byte_t tx_byte_o
);
  import holo_bridge_pkg::*;

  byte_t        mem [REPLY_DEPTH];
  reply_ptr_t   wr_ptr;
  reply_ptr_t   rd_ptr;
  reply_cnt_t   count;
  reply_state_t state;
  // tx_active seen high for the current byte
  logic         seen_active;
  logic         full;
  logic         empty;
  logic         wr_en;
  logic         rd_en;

  assign full  = (count == reply_cnt_t'(REPLY_DEPTH));
  assign empty = (count == '0);
  assign wr_en = xfer.done & ~full;
  assign rd_en = (state == RQ_IDLE) & ~empty & ~tx_active_i;

  ////////////////////////////////////////////////////////////////////////////
  // circular buffer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= xfer.rx_byte;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at the depth
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read then start sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state       <= RQ_IDLE;
      seen_active <= 1'b0;
      tx_start_o  <= 1'b0;
    end else begin
      tx_start_o <= 1'b0;
      case (state)
        RQ_IDLE: begin
          seen_active <= 1'b0;
          // byte registered here, start strobe one cycle later
          if (rd_en) begin
            tx_byte_o <= mem[rd_ptr];
            state     <= RQ_LAUNCH;
          end
        end
        RQ_LAUNCH: begin
          tx_start_o <= 1'b1;
          state      <= RQ_WAIT_ACTIVE;
        end
        RQ_WAIT_ACTIVE: begin
          // wait for the transmitter to go busy and then idle
          if (tx_active_i) begin
            seen_active <= 1'b1;
          end else if (seen_active) begin
            state <= RQ_IDLE;
          end
        end
        default: state <= RQ_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/reset_stretcher.sv
// output follows the command combinationally, hold length fixed by RESET_HOLD_CYCLES
`timescale 1ns/1ps

module reset_stretcher (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  output logic slm_reset_n_o
);
  import holo_bridge_pkg::*;

  hold_cnt_t hold_cnt;

  // reload while commanded, count down afterwards
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      hold_cnt <= RESET_HOLD_CYCLES;
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // active low slm reset
  assign slm_reset_n_o = ~(reset_all_cmd_w | (hold_cnt != '0));

endmodule

// File: hdl/byte_pairer.sv
// no framing between bytes; a lost byte shifts every later pair by one
`timescale 1ns/1ps

module byte_pairer (
  input  logic                   sys_clk,
  input  logic                   reset_all_cmd_w,
  input  logic                   rx_valid_i,
  input  holo_bridge_pkg::byte_t rx_byte_i,
  spi_xfer_if.requester          xfer
);

  // high when the next byte completes a pair
  logic second_byte;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      second_byte <= 1'b0;
      xfer.start  <= 1'b0;
    end else begin
      xfer.start <= 1'b0;
      if (rx_valid_i) begin
        // previous byte becomes the address
        xfer.addr_byte <= xfer.data_byte;
        xfer.data_byte <= rx_byte_i;
        second_byte    <= ~second_byte;
        // launch on every even byte
        if (second_byte) begin
          xfer.start <= 1'b1;
        end
      end
    end
  end

endmodule

// File: hdl/spi_master.sv
// mode 0, 16-bit frames only; start is ignored while a frame is in flight
`timescale 1ns/1ps

module spi_master (
  input  logic       sys_clk,
  input  logic       reset_all_cmd_w,
  spi_xfer_if.engine xfer,
  output logic       sen_o,
  output logic       sck_o,
  output logic       sdat_o,
  input  logic       sout_i
);
  import holo_bridge_pkg::*;

  spi_state_t state;
  spi_half_t  half_cnt;
  // sck toggles done so far in this frame
  spi_edge_t  edge_cnt;
  spi_word_t  tx_shift;
  byte_t      rx_shift;

  // last 8 bits sampled are the read-back byte
  assign xfer.rx_byte = rx_shift;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state     <= SPI_IDLE;
      half_cnt  <= '0;
      edge_cnt  <= '0;
      sen_o     <= 1'b1;
      sck_o     <= 1'b0;
      sdat_o    <= 1'b0;
      xfer.done <= 1'b0;
    end else begin
      xfer.done <= 1'b0;
      case (state)
        SPI_IDLE: begin
          if (xfer.start) begin
            tx_shift <= {xfer.addr_byte, xfer.data_byte};
            // address msb goes out first
            sdat_o   <= xfer.addr_byte[7];
            sen_o    <= 1'b0;
            half_cnt <= '0;
            edge_cnt <= '0;
            state    <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (half_cnt == spi_half_t'(SPI_HALF_PERIOD - 1)) begin
            half_cnt <= '0;
            sck_o    <= ~sck_o;
            edge_cnt <= edge_cnt + 1'b1;
            if (!sck_o) begin
              // rising edge, capture sout
              rx_shift <= {rx_shift[6:0], sout_i};
            end else begin
              // falling edge, present next bit
              tx_shift <= {tx_shift[14:0], 1'b0};
              sdat_o   <= tx_shift[14];
            end
            // 31st toggle is the last rising edge
            if (edge_cnt == spi_edge_t'(2 * SPI_FRAME_BITS - 2)) begin
              state <= SPI_FINISH;
            end
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        SPI_FINISH: begin
          // hold the last high phase, then close the frame
          if (half_cnt == spi_half_t'(SPI_HALF_PERIOD - 1)) begin
            half_cnt  <= '0;
            sck_o     <= 1'b0;
            sen_o     <= 1'b1;
            xfer.done <= 1'b1;
            state     <= SPI_IDLE;
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/uart_tx.sv
// 8N1 only; a start strobe while tx_active_o is high is ignored
`timescale 1ns/1ps

module uart_tx #(
  parameter int clks_per_bit = holo_bridge_pkg::CLKS_PER_BIT_DEFAULT
) (
  input  logic                   sys_clk,
  input  logic                   reset_all_cmd_w,
  input  logic                   tx_start_i,
  input  holo_bridge_pkg::byte_t tx_byte_i,
  output logic                   tx_active_o,
  output logic                   tx_serial_o
);
  import holo_bridge_pkg::*;

  typedef logic [$clog2(clks_per_bit)-1:0] clk_cnt_t;

  uart_state_t state;
  clk_cnt_t    clk_cnt;
  logic [2:0]  bit_idx;
  // shifts right, bit 0 is next on the line
  byte_t       data_r;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state       <= UART_IDLE;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      tx_active_o <= 1'b0;
      tx_serial_o <= 1'b1;
    end else begin
      case (state)
        UART_IDLE: begin
          clk_cnt <= '0;
          if (tx_start_i) begin
            data_r      <= tx_byte_i;
            tx_active_o <= 1'b1;
            // start bit
            tx_serial_o <= 1'b0;
            state       <= UART_START;
          end
        end
        UART_START: begin
          if (clk_cnt == clk_cnt_t'(clks_per_bit - 1)) begin
            clk_cnt     <= '0;
            bit_idx     <= '0;
            tx_serial_o <= data_r[0];
            data_r      <= {1'b0, data_r[7:1]};
            state       <= UART_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_DATA: begin
          if (clk_cnt == clk_cnt_t'(clks_per_bit - 1)) begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7) begin
              // stop bit
              tx_serial_o <= 1'b1;
              state       <= UART_STOP;
            end else begin
              bit_idx     <= bit_idx + 1'b1;
              tx_serial_o <= data_r[0];
              data_r      <= {1'b0, data_r[7:1]};
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_STOP: begin
          // active drops as the stop bit ends
          if (clk_cnt == clk_cnt_t'(clks_per_bit - 1)) begin
            tx_active_o <= 1'b0;
            state       <= UART_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/uart_rx.sv
// 8N1 only, no parity; clks_per_bit must be at least 4 for a clean mid-bit sample
`timescale 1ns/1ps

module uart_rx #(
  parameter int clks_per_bit = holo_bridge_pkg::CLKS_PER_BIT_DEFAULT
) (
  input  logic                   sys_clk,
  input  logic                   reset_all_cmd_w,
  input  logic                   rx_serial_i,
  output logic                   rx_valid_o,
  output holo_bridge_pkg::byte_t rx_byte_o
);
  import holo_bridge_pkg::*;

  typedef logic [$clog2(clks_per_bit)-1:0] clk_cnt_t;

  uart_state_t state;
  clk_cnt_t    clk_cnt;
  logic [2:0]  bit_idx;
  // two-flop sync on the async line
  logic        rx_meta;
  logic        rx_s;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
    end else begin
      rx_meta <= rx_serial_i;
      rx_s    <= rx_meta;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state      <= UART_IDLE;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state)
        UART_IDLE: begin
          clk_cnt <= '0;
          // falling edge means a possible start bit
          if (!rx_s) begin
            state <= UART_START;
          end
        end
        UART_START: begin
          // confirm start at half a bit, glitches go back to idle
          if (clk_cnt == clk_cnt_t'((clks_per_bit - 1) / 2)) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_s ? UART_IDLE : UART_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_DATA: begin
          if (clk_cnt == clk_cnt_t'(clks_per_bit - 1)) begin
            clk_cnt            <= '0;
            // lsb first, sampled at bit centre
            rx_byte_o[bit_idx] <= rx_s;
            if (bit_idx == 3'd7) begin
              state <= UART_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_STOP: begin
          // middle of stop bit, framing error drops the byte
          if (clk_cnt == clk_cnt_t'(clks_per_bit - 1)) begin
            rx_valid_o <= rx_s;
            state      <= UART_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/spi_xfer_if.sv
// strobes only, no handshake; start is ignored while the spi engine is busy
`timescale 1ns/1ps

interface spi_xfer_if;
  import holo_bridge_pkg::*;

  // request side
  logic  start;
  byte_t addr_byte;
  byte_t data_byte;
  // result side, done is a single-cycle pulse
  logic  done;
  byte_t rx_byte;

  modport requester (output start, output addr_byte, output data_byte);
  modport engine (input start, input addr_byte, input data_byte, output done, output rx_byte);
  modport result (input done, input rx_byte);

endinterface

// File: hdl/holo_bridge_pkg.sv
// shared types and constants; the default UART rate assumes a 100 MHz sys_clk
package holo_bridge_pkg;

  // one uart or spi byte
  typedef logic [7:0] byte_t;
  // spi frame, address byte in the upper half
  typedef logic [15:0] spi_word_t;

  // 100 MHz / 115200 baud
  localparam int CLKS_PER_BIT_DEFAULT = 868;

  // sck half period in sys_clk cycles
  localparam int SPI_HALF_PERIOD = 4;
  localparam int SPI_FRAME_BITS = 16;
  localparam int SPI_HALF_W = $clog2(SPI_HALF_PERIOD);
  localparam int SPI_EDGE_W = $clog2(2 * SPI_FRAME_BITS);
  typedef logic [SPI_HALF_W-1:0] spi_half_t;
  typedef logic [SPI_EDGE_W-1:0] spi_edge_t;

  // slm reset hold after the command drops
  typedef logic [3:0] hold_cnt_t;
  localparam hold_cnt_t RESET_HOLD_CYCLES = 4'd10;

  // reply fifo geometry
  localparam int REPLY_DEPTH = 4;
  localparam int REPLY_PTR_W = 2;
  typedef logic [REPLY_PTR_W-1:0] reply_ptr_t;
  typedef logic [REPLY_PTR_W:0] reply_cnt_t;

  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_t;
  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_FINISH} spi_state_t;
  typedef enum logic [1:0] {RQ_IDLE, RQ_LAUNCH, RQ_WAIT_ACTIVE} reply_state_t;

endpackage
